//--- proc.f
+incdir+common
common/procPkg.sv
fetch/fetchUnit.sv
decode/instrDecode.sv
logic/regFile.sv
logic/hazardUnit.sv
execute/executeStage.sv
logic/proc.sv
tb/clkGen.sv
tb/procChk.sv
tb/procTb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := procTb
FILELIST  := proc.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tb/procTb.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module procTb import procPkg::*; ();

   localparam int NUM_TESTS = 6;
   localparam int CYCLES_PER_TEST = 200;
   localparam int TIMEOUT_CYCLES = NUM_TESTS * CYCLES_PER_TEST;
   localparam int RESET_CYCLES = 5;
   localparam int SETTLE_CYCLES = 8;
   localparam wordT HALT_WORD = {`OP_HALT, 11'b0};

   logic clk, rstN, dmemEn, dmemWr, halted, err;
   wordT imemAddr, imemData, dmemAddr, dmemWdata, dmemRdata;

   wordT rom [256];
   wordT ram [256];
   wordT storeAddrs[$];
   wordT storeData[$];
   wordT expAddrs[$];
   wordT expData[$];
   int progLen;
   int wordErrors;
   int flagErrors;
   int assertErrors;
   int cycleCount;
   integer seed = 32'h54bb;

   clkGen #(.PERIOD(20)) clockSource (.clk(clk));

   proc UUT (
      .clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData), .dmemEn(dmemEn),
      .dmemWr(dmemWr), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemRdata(dmemRdata),
      .halted(halted), .err(err)
   );

   bind proc procChk chk (
      .clk(clk), .rstN(rstN), .halted(halted), .dmemEn(dmemEn), .dmemWr(dmemWr)
   );

   // One ROM word per even byte address
   assign imemData  = rom[imemAddr[8:1]];
   // RAM indexed by the low address byte
   // Read data valid only during a data access
   assign dmemRdata = (dmemEn === 1'b1) ? ram[dmemAddr[7:0]] : 'x;

   // Fill pattern in reset and edge-written stores afterwards
   always @(posedge clk) begin
      if (rstN !== 1'b1) begin
         for (int i = 0; i < 256; i++) begin
            ram[i] <= wordT'(i) * 16'h0101 ^ 16'h5AC3;
         end
      end else if (dmemEn === 1'b1 && dmemWr === 1'b1) begin
         ram[dmemAddr[7:0]] <= dmemWdata;
      end
   end

   // Store log sampled mid-cycle
   always @(negedge clk) begin
      if (rstN !== 1'b1) begin
         storeAddrs.delete();
         storeData.delete();
      end else if (dmemEn === 1'b1 && dmemWr === 1'b1) begin
         storeAddrs.push_back(dmemAddr);
         storeData.push_back(dmemWdata);
      end
   end

   // Watchdog
   initial begin
      cycleCount = 0;
      while (cycleCount < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("Timeout: no verdict after %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

   task automatic checkWord(input string name, input wordT got, input wordT exp);
      if (got !== exp) begin
         wordErrors++;
         $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         flagErrors++;
         $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // Instruction word builders per format
   function automatic wordT immForm(opcodeT op, regIdxT rs, regIdxT rt, logic [4:0] imm5);
      return {op, rs, rt, imm5};
   endfunction

   function automatic wordT lbiInstr(regIdxT rs, logic [7:0] imm8);
      return {`OP_LBI, rs, imm8};
   endfunction

   function automatic wordT aluInstr(regIdxT rs, regIdxT rt, regIdxT rd, aluFnT fn);
      return {`OP_ALU, rs, rt, rd, fn};
   endfunction

   function automatic wordT branchInstr(opcodeT op, regIdxT rs, logic [7:0] disp);
      return {op, rs, disp};
   endfunction

   function automatic wordT jumpInstr(logic [10:0] disp);
      return {`OP_J, disp};
   endfunction

   function automatic wordT signExt8(logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   // Runaway fetch lands on HALT
   task automatic clearProgram();
      for (int i = 0; i < 256; i++) begin
         rom[i] = HALT_WORD;
      end
      progLen = 0;
      expAddrs.delete();
      expData.delete();
   endtask

   task automatic emit(input wordT instr);
      rom[progLen] = instr;
      progLen++;
   endtask

   task automatic expectStore(input wordT addr, input wordT data);
      expAddrs.push_back(addr);
      expData.push_back(data);
   endtask

   task automatic resetDut();
      @(posedge clk);
      #1 rstN = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rstN = 1'b1;
      @(negedge clk);
      checkFlag("halted after reset", halted, 1'b0);
   endtask

   task automatic compareStores(input string name);
      int n;
      n = (storeAddrs.size() < expAddrs.size()) ? storeAddrs.size() : expAddrs.size();
      if (storeAddrs.size() != expAddrs.size()) begin
         $display("%s: %0d stores logged where %0d were expected", name,
                  storeAddrs.size(), expAddrs.size());
      end
      checkFlag({name, " store count"}, logic'(storeAddrs.size() == expAddrs.size()), 1'b1);
      for (int i = 0; i < n; i++) begin
         checkWord($sformatf("%s store %0d addr", name, i), storeAddrs[i], expAddrs[i]);
         checkWord($sformatf("%s store %0d data", name, i), storeData[i], expData[i]);
      end
   endtask

   // Reset and run to HALT then watch a few more cycles
   task automatic runProgram(input string name);
      resetDut();
      while (halted !== 1'b1) @(negedge clk);
      repeat (SETTLE_CYCLES) begin
         @(negedge clk);
         checkFlag({name, " halted"}, halted, 1'b1);
      end
      checkFlag({name, " err"}, err, 1'b0);
      compareStores(name);
   endtask

   // Dependent chain forwarding from EX, MEM and WB
   task automatic testAluChain();
      logic [7:0] immA, immB;
      wordT a, b, r2, r3, r5, r6, r7;
      immA = 8'($random(seed));
      immB = 8'($random(seed));
      a = signExt8(immA);
      b = signExt8(immB);
      r2 = a - 16'd3;
      r3 = r2 + a;
      r5 = r3 - b;
      r6 = r5 ^ r2;
      r7 = r6 & b;
      clearProgram();
      emit(lbiInstr(3'd1, immA));
      emit(immForm(`OP_ADDI, 3'd1, 3'd2, 5'h1D));
      emit(aluInstr(3'd2, 3'd1, 3'd3, `FN_ADD));
      emit(lbiInstr(3'd4, immB));
      emit(aluInstr(3'd3, 3'd4, 3'd5, `FN_SUB));
      emit(aluInstr(3'd5, 3'd2, 3'd6, `FN_XOR));
      emit(aluInstr(3'd6, 3'd4, 3'd7, `FN_AND));
      emit(immForm(`OP_ST, 3'd0, 3'd7, 5'd1));
      emit(immForm(`OP_ST, 3'd0, 3'd6, 5'd2));
      emit(immForm(`OP_ST, 3'd0, 3'd5, 5'd3));
      emit(immForm(`OP_ST, 3'd0, 3'd3, 5'd4));
      emit(immForm(`OP_ST, 3'd0, 3'd2, 5'd5));
      emit(HALT_WORD);
      expectStore(16'd1, r7);
      expectStore(16'd2, r6);
      expectStore(16'd3, r5);
      expectStore(16'd4, r3);
      expectStore(16'd5, r2);
      runProgram("aluChain");
   endtask

   // Load then immediate use by an ALU operand and by store data
   task automatic testLoadUse();
      wordT v, sum;
      v = 16'h005B;
      sum = (v + 16'd1) + v;
      clearProgram();
      emit(lbiInstr(3'd1, 8'h5B));
      emit(lbiInstr(3'd2, 8'h06));
      emit(immForm(`OP_ST, 3'd2, 3'd1, 5'd1));
      emit(immForm(`OP_LD, 3'd2, 3'd3, 5'd1));
      emit(immForm(`OP_ADDI, 3'd3, 3'd4, 5'd1));
      emit(aluInstr(3'd4, 3'd3, 3'd5, `FN_ADD));
      emit(immForm(`OP_ST, 3'd2, 3'd5, 5'd2));
      emit(immForm(`OP_LD, 3'd2, 3'd6, 5'd2));
      emit(immForm(`OP_ST, 3'd0, 3'd6, 5'd9));
      emit(HALT_WORD);
      expectStore(16'd7, v);
      expectStore(16'd8, sum);
      expectStore(16'd9, sum);
      runProgram("loadUse");
   endtask

   // Taken BEQZ skips two markers and the not-taken one falls through
   task automatic testBeqz();
      clearProgram();
      emit(lbiInstr(3'd1, 8'h00));
      emit(lbiInstr(3'd2, 8'h03));
      emit(lbiInstr(3'd7, 8'h11));
      emit(branchInstr(`OP_BEQZ, 3'd1, 8'd4));
      emit(immForm(`OP_ST, 3'd0, 3'd7, 5'd1));
      emit(immForm(`OP_ST, 3'd0, 3'd7, 5'd2));
      emit(branchInstr(`OP_BEQZ, 3'd2, 8'd4));
      emit(immForm(`OP_ST, 3'd0, 3'd7, 5'd3));
      emit(immForm(`OP_ST, 3'd0, 3'd7, 5'd4));
      emit(HALT_WORD);
      expectStore(16'd3, 16'h0011);
      expectStore(16'd4, 16'h0011);
      runProgram("beqz");
   endtask

   task automatic testBnez();
      clearProgram();
      emit(lbiInstr(3'd1, 8'h05));
      emit(lbiInstr(3'd7, 8'h22));
      emit(branchInstr(`OP_BNEZ, 3'd1, 8'd4));
      emit(immForm(`OP_ST, 3'd0, 3'd7, 5'd1));
      emit(immForm(`OP_ST, 3'd0, 3'd7, 5'd2));
      emit(lbiInstr(3'd3, 8'h00));
      emit(branchInstr(`OP_BNEZ, 3'd3, 8'd4));
      emit(immForm(`OP_ST, 3'd0, 3'd7, 5'd3));
      emit(immForm(`OP_ST, 3'd0, 3'd7, 5'd4));
      emit(HALT_WORD);
      expectStore(16'd3, 16'h0022);
      expectStore(16'd4, 16'h0022);
      runProgram("bnez");
   endtask

   // Forward J over markers then a counted loop closed by a backward J
   task automatic testJumpLoop();
      int loops;
      loops = 4;
      clearProgram();
      emit(lbiInstr(3'd1, 8'(loops)));
      emit(lbiInstr(3'd2, 8'h00));
      emit(jumpInstr(11'd4));
      emit(immForm(`OP_ST, 3'd0, 3'd1, 5'd15));
      emit(immForm(`OP_ST, 3'd0, 3'd1, 5'd14));
      emit(immForm(`OP_ST, 3'd2, 3'd1, 5'd1));
      emit(immForm(`OP_ADDI, 3'd2, 3'd2, 5'd1));
      emit(immForm(`OP_ADDI, 3'd1, 3'd1, 5'h1F));
      emit(branchInstr(`OP_BEQZ, 3'd1, 8'd2));
      // Back to the loop head at address 10 from pcInc 20
      emit(jumpInstr(11'h7F6));
      emit(HALT_WORD);
      for (int k = 0; k < loops; k++) begin
         expectStore(wordT'(k + 1), wordT'(loops - k));
      end
      runProgram("jumpLoop");
   endtask

   // Stores behind HALT never issue and halted holds until reset
   task automatic testHaltHold();
      clearProgram();
      emit(lbiInstr(3'd1, 8'h33));
      emit(immForm(`OP_ST, 3'd0, 3'd1, 5'd1));
      emit(HALT_WORD);
      emit(immForm(`OP_ST, 3'd0, 3'd1, 5'd2));
      emit(immForm(`OP_ST, 3'd0, 3'd1, 5'd3));
      expectStore(16'd1, 16'h0033);
      runProgram("haltHold");
      resetDut();
   endtask

   initial begin
      rstN = 1'b0;
      wordErrors = 0;
      flagErrors = 0;
      assertErrors = 0;
      testAluChain();
      testLoadUse();
      testBeqz();
      testBnez();
      testJumpLoop();
      testHaltHold();
      assertErrors = UUT.chk.failCount;
      $display("Errors: %0d word, %0d flag, %0d assertion, %0d total", wordErrors,
               flagErrors, assertErrors, wordErrors + flagErrors + assertErrors);
      if (wordErrors + flagErrors + assertErrors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- tb/procChk.sv
`timescale 1ns/1ps

module procChk (
   input logic clk,
   input logic rstN,
   input logic halted,
   input logic dmemEn,
   input logic dmemWr
);

   // Failed assertions so far
   int failCount = 0;

   // Only reset may clear halted
   haltedSticky: assert property (
      @(posedge clk) (rstN && $past(rstN)) |-> !$fell(halted)
   ) else begin
      failCount++;
      $error("halted fell while out of reset");
   end

   // Nothing younger than HALT may reach data memory
   noStoreHalted: assert property (
      @(posedge clk) disable iff (!rstN) halted |-> !(dmemEn && dmemWr)
   ) else begin
      failCount++;
      $error("store issued while halted");
   end

   // MEM stage holds a bubble right after reset
   quietAfterReset: assert property (
      @(posedge clk) !rstN |=> !dmemEn
   ) else begin
      failCount++;
      $error("dmemEn high in the cycle after reset");
   end

endmodule

//--- tb/clkGen.sv
`timescale 1ns/1ps

module clkGen #(
   parameter int PERIOD = 20
) (
   output logic clk
);

   // Starts low, first rising edge at half a period
   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

endmodule

//--- logic/proc.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module proc import procPkg::*; (
   input  logic clk,
   input  logic rstN,
   output wordT imemAddr,
   input  wordT imemData,
   output logic dmemEn,
   output logic dmemWr,
   output wordT dmemAddr,
   output wordT dmemWdata,
   input  wordT dmemRdata,
   output logic halted,
   output logic err
);

   // Fetch and hazard control
   wordT pcInc, target;
   logic stall, branchTaken, rawTaken, haltNow, bubble;

   // Decode stage
   wordT idInstr, idPcInc, idImm, rfRd1, rfRd2, idOpA, idOpB;
   regIdxT idRs1, idRs2, idRd;
   aluFnT idFn;
   logic idWe, idUseImm, idLoad, idStore, idBranch, idJump, idHalt, idLoadImm;
   logic [1:0] fwd1, fwd2;
   logic memFwdLoad;

   // Execute stage
   wordT exInstr, exPcInc, exOpA, exOpB, exImm, exResult;
   regIdxT exRd;
   aluFnT exFn;
   logic exWe, exUseImm, exLoadImm, exLoad, exStore, exBranch, exJump, exHalt;

   // Memory and writeback stages
   wordT memAlu, memStData, memFwdData, wbAlu, wbLoadData, wbData;
   regIdxT memRd, wbRd;
   logic memWe, memLoad, memStore, memHalt, wbWe, wbLoad;

   function automatic wordT fwdPick(logic [1:0] sel, wordT exV, wordT memV, wordT wbV,
                                    wordT rfV);
      case (sel)
         2'b11: fwdPick = exV;
         2'b10: fwdPick = memV;
         2'b01: fwdPick = wbV;
         default: fwdPick = rfV;
      endcase
   endfunction

   assign err = 1'b0;

   // HALT in MEM freezes the front end from this cycle on
   assign haltNow = memHalt || halted;
   // Anything younger than HALT must not redirect fetch
   assign branchTaken = rawTaken && !haltNow;
   assign bubble = stall || branchTaken || haltNow;

   fetchUnit fetch (
      .clk(clk), .rstN(rstN), .stall(stall), .halted(haltNow),
      .branchTaken(branchTaken), .target(target), .pc(imemAddr), .pcInc(pcInc)
   );

   // IF/ID
   always_ff @(posedge clk) begin
      if (!rstN || branchTaken || haltNow) begin
         idInstr <= `NOP_WORD;
      end else if (!stall) begin
         idInstr <= imemData;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         idPcInc <= pcInc;
      end
   end

   instrDecode decode (
      .instr(idInstr), .rs1(idRs1), .rs2(idRs2), .rd(idRd), .regWe(idWe), .imm(idImm),
      .aluFn(idFn), .useImm(idUseImm), .isLoad(idLoad), .isStore(idStore),
      .isBranch(idBranch), .isJump(idJump), .isHalt(idHalt), .loadImm(idLoadImm)
   );

   regFile rf (
      .clk(clk), .rstN(rstN), .rs1(idRs1), .rs2(idRs2), .rd1(rfRd1), .rd2(rfRd2),
      .wrIdx(wbRd), .wrData(wbData), .wrEn(wbWe)
   );

   hazardUnit hazard (
      .rs1(idRs1), .rs2(idRs2), .exRd(exRd), .exWe(exWe), .exLoad(exLoad),
      .memRd(memRd), .memWe(memWe), .memLoad(memLoad), .wbRd(wbRd), .wbWe(wbWe),
      .fwd1(fwd1), .fwd2(fwd2), .memFwdLoad(memFwdLoad), .stall(stall)
   );

   // Operand forwarding into decode
   assign memFwdData = memFwdLoad ? dmemRdata : memAlu;
   assign idOpA = fwdPick(fwd1, exResult, memFwdData, wbData, rfRd1);
   assign idOpB = fwdPick(fwd2, exResult, memFwdData, wbData, rfRd2);

   // ID/EX control, bubble on stall, squash or halt
   always_ff @(posedge clk) begin
      if (!rstN || bubble) begin
         exInstr  <= `NOP_WORD;
         exWe     <= 1'b0;
         exLoad   <= 1'b0;
         exStore  <= 1'b0;
         exBranch <= 1'b0;
         exJump   <= 1'b0;
         exHalt   <= 1'b0;
      end else begin
         exInstr  <= idInstr;
         exWe     <= idWe;
         exLoad   <= idLoad;
         exStore  <= idStore;
         exBranch <= idBranch;
         exJump   <= idJump;
         exHalt   <= idHalt;
      end
   end

   // ID/EX payload
   always_ff @(posedge clk) begin
      exPcInc   <= idPcInc;
      exOpA     <= idOpA;
      exOpB     <= idOpB;
      exImm     <= idImm;
      exFn      <= idFn;
      exUseImm  <= idUseImm;
      exLoadImm <= idLoadImm;
      exRd      <= idRd;
   end

   executeStage execute (
      .opA(exOpA), .opB(exOpB), .imm(exImm), .aluFn(exFn), .useImm(exUseImm),
      .loadImm(exLoadImm), .isBranch(exBranch), .isJump(exJump),
      .brNotZero(exInstr[15:11] == `OP_BNEZ), .pcInc(exPcInc),
      .result(exResult), .branchTaken(rawTaken), .target(target)
   );

   // EX/MEM, younger than a HALT in MEM is dropped
   always_ff @(posedge clk) begin
      if (!rstN || haltNow) begin
         memWe    <= 1'b0;
         memLoad  <= 1'b0;
         memStore <= 1'b0;
         memHalt  <= 1'b0;
      end else begin
         memWe    <= exWe;
         memLoad  <= exLoad;
         memStore <= exStore;
         memHalt  <= exHalt;
      end
   end

   always_ff @(posedge clk) begin
      memAlu    <= exResult;
      memStData <= exOpB;
      memRd     <= exRd;
   end

   // Data memory port, read data valid this cycle
   assign dmemEn    = memLoad || memStore;
   assign dmemWr    = memStore;
   assign dmemAddr  = memAlu;
   assign dmemWdata = memStData;

   // Sticky until reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         halted <= 1'b0;
      end else if (memHalt) begin
         halted <= 1'b1;
      end
   end

   // MEM/WB
   always_ff @(posedge clk) begin
      if (!rstN) begin
         wbWe   <= 1'b0;
         wbLoad <= 1'b0;
      end else begin
         wbWe   <= memWe;
         wbLoad <= memLoad;
      end
   end

   always_ff @(posedge clk) begin
      wbAlu      <= memAlu;
      wbLoadData <= dmemRdata;
      wbRd       <= memRd;
   end

   // Writeback select
   assign wbData = wbLoad ? wbLoadData : wbAlu;

endmodule

//--- execute/executeStage.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module executeStage import procPkg::*; (
   input  wordT  opA,
   input  wordT  opB,
   input  wordT  imm,
   input  aluFnT aluFn,
   input  logic  useImm,
   input  logic  loadImm,
   input  logic  isBranch,
   input  logic  isJump,
   input  logic  brNotZero,
   input  wordT  pcInc,
   output wordT  result,
   output logic  branchTaken,
   output wordT  target
);

   wordT aluB;
   wordT aluOut;
   logic rsZero;

   // Immediate forms replace Rt
   assign aluB = useImm ? imm : opB;

   always_comb begin
      case (aluFn)
         `FN_SUB: aluOut = opA - aluB;
         `FN_XOR: aluOut = opA ^ aluB;
         `FN_AND: aluOut = opA & aluB;
         default: aluOut = opA + aluB;
      endcase
   end

   // LBI passes the immediate straight through
   assign result = loadImm ? imm : aluOut;

   // Branch condition on Rs
   assign rsZero = (opA == '0);
   assign branchTaken = isJump || (isBranch && (brNotZero ? !rsZero : rsZero));

   // Displacement is relative to the next instruction
   assign target = pcInc + imm;

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import procPkg::*; (
   input  regIdxT     rs1,
   input  regIdxT     rs2,
   input  regIdxT     exRd,
   input  logic       exWe,
   input  logic       exLoad,
   input  regIdxT     memRd,
   input  logic       memWe,
   input  logic       memLoad,
   input  regIdxT     wbRd,
   input  logic       wbWe,
   output logic [1:0] fwd1,
   output logic [1:0] fwd2,
   output logic       memFwdLoad,
   output logic       stall
);

   logic exHit1, exHit2, memHit1, memHit2, wbHit1, wbHit2;

   // Select encoding
   // 11 EX result, 10 MEM, 01 WB write data, 00 register file
   function automatic logic [1:0] pickFwd(logic exHit, logic memHit, logic wbHit);
      if (exHit) begin
         pickFwd = 2'b11;
      end else if (memHit) begin
         pickFwd = 2'b10;
      end else if (wbHit) begin
         pickFwd = 2'b01;
      end else begin
         pickFwd = 2'b00;
      end
   endfunction

   assign exHit1  = exWe && (exRd == rs1);
   assign exHit2  = exWe && (exRd == rs2);
   assign memHit1 = memWe && (memRd == rs1);
   assign memHit2 = memWe && (memRd == rs2);
   assign wbHit1  = wbWe && (wbRd == rs1);
   assign wbHit2  = wbWe && (wbRd == rs2);

   // Load in EX only has an address, so wait one cycle
   assign stall = exLoad && (exHit1 || exHit2);

   // Youngest writer wins, never a load still in EX
   assign fwd1 = pickFwd(exHit1 && !exLoad, memHit1, wbHit1);
   assign fwd2 = pickFwd(exHit2 && !exLoad, memHit2, wbHit2);

   // MEM load returns memory data, not its address
   assign memFwdLoad = memLoad;

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module regFile import procPkg::*; (
   input  logic   clk,
   input  logic   rstN,
   input  regIdxT rs1,
   input  regIdxT rs2,
   output wordT   rd1,
   output wordT   rd2,
   input  regIdxT wrIdx,
   input  wordT   wrData,
   input  logic   wrEn
);

   wordT regs [`NUM_REGS];

   // One write port, at the edge
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrIdx] <= wrData;
      end
   end

   // Combinational reads
   // Same-cycle write shows up next cycle, WB forward bridges the gap
   assign rd1 = regs[rs1];
   assign rd2 = regs[rs2];

endmodule

//--- decode/instrDecode.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module instrDecode import procPkg::*; (
   input  wordT   instr,
   output regIdxT rs1,
   output regIdxT rs2,
   output regIdxT rd,
   output logic   regWe,
   output wordT   imm,
   output aluFnT  aluFn,
   output logic   useImm,
   output logic   isLoad,
   output logic   isStore,
   output logic   isBranch,
   output logic   isJump,
   output logic   isHalt,
   output logic   loadImm
);

   opcodeT op;
   wordT   imm5;
   wordT   imm8;
   wordT   imm11;

   assign op = instr[15:11];

   // Read selects are fixed fields, Rs and Rt
   assign rs1 = instr[10:8];
   assign rs2 = instr[7:5];

   // Sign-extended immediate per format
   assign imm5  = {{(`DATA_W-5){instr[4]}}, instr[4:0]};
   assign imm8  = {{(`DATA_W-8){instr[7]}}, instr[7:0]};
   assign imm11 = {{(`DATA_W-11){instr[10]}}, instr[10:0]};

   always_comb begin
      // Defaults behave as NOP
      rd       = instr[4:2];
      regWe    = 1'b0;
      imm      = imm5;
      aluFn    = `FN_ADD;
      useImm   = 1'b0;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      isBranch = 1'b0;
      isJump   = 1'b0;
      isHalt   = 1'b0;
      loadImm  = 1'b0;
      case (op)
         `OP_ALU: begin
            regWe = 1'b1;
            aluFn = instr[1:0];
         end
         `OP_ADDI: begin
            rd     = instr[7:5];
            regWe  = 1'b1;
            useImm = 1'b1;
         end
         // Address is Rs + offset
         `OP_LD: begin
            rd     = instr[7:5];
            regWe  = 1'b1;
            useImm = 1'b1;
            isLoad = 1'b1;
         end
         // Store data rides on the Rt operand
         `OP_ST: begin
            useImm  = 1'b1;
            isStore = 1'b1;
         end
         `OP_LBI: begin
            rd      = instr[10:8];
            regWe   = 1'b1;
            imm     = imm8;
            loadImm = 1'b1;
         end
         `OP_BEQZ, `OP_BNEZ: begin
            imm      = imm8;
            isBranch = 1'b1;
         end
         `OP_J: begin
            imm    = imm11;
            isJump = 1'b1;
         end
         `OP_HALT: isHalt = 1'b1;
         // NOP and unused opcodes
         default: ;
      endcase
   end

endmodule

//--- fetch/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import procPkg::*; (
   input  logic clk,
   input  logic rstN,
   input  logic stall,
   input  logic halted,
   input  logic branchTaken,
   input  wordT target,
   output wordT pc,
   output wordT pcInc
);

   wordT pcNext;

   // Byte addressed, two bytes per instruction
   assign pcInc = pc + wordT'(2);

   // Redirect wins over hold
   always_comb begin
      if (branchTaken) begin
         pcNext = target;
      end else if (stall || halted) begin
         pcNext = pc;
      end else begin
         pcNext = pcInc;
      end
   end

   // First fetch after reset from address 0
   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
      end else begin
         pc <= pcNext;
      end
   end

endmodule

//--- common/procPkg.sv
`include "proc_defs.svh"

package procPkg;

   // Data, address and instruction word
   typedef logic [`DATA_W-1:0] wordT;

   // Register index, Rs / Rt / Rd fields
   typedef logic [$clog2(`NUM_REGS)-1:0] regIdxT;

   // Opcode field, top five bits of the instruction
   typedef logic [4:0] opcodeT;

   // R-format function select
   // Immediate forms always decode to add
   typedef logic [1:0] aluFnT;

endpackage

//--- common/proc_defs.svh
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// Datapath width and register count
`define DATA_W   16
`define NUM_REGS 8

// Canonical NOP, used for squash and bubbles
`define NOP_WORD 16'h0800

// Opcodes, instr[15:11]
`define OP_HALT 5'b00000
`define OP_NOP  5'b00001
`define OP_ADDI 5'b01000
`define OP_J    5'b00100
`define OP_BEQZ 5'b01100
`define OP_BNEZ 5'b01101
`define OP_ST   5'b10000
`define OP_LD   5'b10001
`define OP_LBI  5'b11000
`define OP_ALU  5'b11011

// R-format function, instr[1:0]
`define FN_ADD 2'b00
`define FN_SUB 2'b01
`define FN_XOR 2'b10
`define FN_AND 2'b11

`endif
